//--- cpc_glue.f
source/cpc_glue_pkg.sv
source/cpu_bus_if.sv
source/ext_page_decoder.sv
source/boot_loader_map.sv
source/mf2_controller.sv
source/mf2_shadow_ram.sv
source/ear_input_select.sv
source/cpc_glue_top.sv
bench/cpc_glue_tb.sv

//--- Bender.yml
package:
  name: cpc_glue

sources:
  - files:
      - source/cpc_glue_pkg.sv
      - source/cpu_bus_if.sv
      - source/ext_page_decoder.sv
      - source/boot_loader_map.sv
      - source/mf2_controller.sv
      - source/mf2_shadow_ram.sv
      - source/ear_input_select.sv
      - source/cpc_glue_top.sv
  - target: test
    files:
      - bench/cpc_glue_tb.sv

//--- bench/cpc_glue_testdata.txt
# kind cycles inputs expected (hex), checked cycles rising edges after the falling-edge drive
# L cyc dl wr idx addr ext rst boot_wr boot_addr bank | M cyc bit map
# C cyc key mode addr dout m1 io_wr rd wr nmi rom ram dout | E cyc ear player tape
# ROM download, chunks 0 to 8
L 1 1 0 00 0000000 0000 1 0 000000 0
L 0 1 1 00 0000000 0000 1 1 000000 0
L 0 1 1 00 0004000 0000 1 1 400000 0
L 0 1 0 00 0004000 0000 1 0 400000 0
L 0 1 1 00 0008123 0000 1 1 41C123 0
L 0 1 1 00 000FFFF 0000 1 1 3FFFFF 0
L 0 1 1 00 0010000 0000 1 1 000000 1
L 0 1 1 00 0014000 0000 1 1 400000 1
L 0 1 1 00 0018005 0000 1 1 41C005 1
L 0 1 1 00 001C000 0000 1 1 3FC000 1
L 0 1 1 00 0020000 0000 1 0 7FC000 0
L 2 0 0 00 0000000 0000 0 0 000000 0
# Expansion downloads 1A, ZZ, QZ
L 1 1 0 03 0000000 3141 1 0 468000 0
M 0 1A 0
L 0 1 1 03 0000000 3141 1 1 468000 0
L 1 1 0 03 0000000 3141 1 0 468000 0
M 0 1A 1
L 1 0 0 03 0000000 3141 0 0 000000 0
L 1 1 0 03 0004010 5A5A 1 0 004010 0
L 0 1 1 03 0004010 5A5A 1 1 004010 0
L 1 1 0 03 0004010 5A5A 1 0 004010 0
M 0 01 0
L 1 0 0 03 0000000 5A5A 0 0 000000 0
L 1 1 0 03 0000000 515A 1 0 7B8000 0
L 1 0 0 03 0000000 515A 0 0 000000 0
# MF2 entry, hiding, then port write with hidden set
C 1 1 0 0000 00 0 0 0 0 1 0 0 FF
C 1 0 0 0000 00 0 0 0 0 1 0 0 FF
C 1 0 0 0066 00 1 0 0 0 0 1 0 FF
C 1 0 0 0100 00 0 0 0 0 0 1 0 FF
C 1 0 0 0065 00 1 0 0 0 0 1 0 FF
C 1 0 0 0065 00 0 0 0 0 0 1 0 FF
C 1 0 0 FEE8 00 0 1 0 0 0 0 0 FF
C 1 0 0 FEE8 00 0 0 0 0 0 0 0 FF
C 1 0 0 FEE8 00 0 1 0 0 0 0 0 FF
C 1 0 0 0100 00 0 0 0 0 0 0 0 FF
# Disabled mode, then FEEA and FEE8 in enabled mode
C 1 1 2 0000 00 0 0 0 0 0 0 0 FF
C 1 0 2 0000 00 0 0 0 0 0 0 0 FF
C 1 1 0 0000 00 0 0 0 0 1 0 0 FF
C 1 0 0 0066 00 1 0 0 0 0 1 0 FF
C 1 0 0 2000 00 0 0 0 0 0 0 1 FF
C 1 0 0 FEEA 00 0 1 0 0 0 0 0 FF
C 1 0 0 2000 00 0 0 0 0 0 0 0 FF
C 1 0 0 FEE8 00 0 1 0 0 0 0 0 FF
C 1 0 0 2000 00 0 0 0 0 0 0 1 FF
# Screen mode store at 1FEF, read back paged in and paged out
C 1 0 0 7F00 8C 0 1 0 0 0 0 0 FF
C 1 0 0 7F00 8C 0 0 0 0 0 0 0 FF
C 2 0 0 3FEF 00 0 0 1 0 0 0 1 8C
C 1 0 0 FEEA 00 0 1 0 0 0 0 0 FF
C 2 0 0 3FEF 00 0 0 1 0 0 0 0 FF
# EAR follows edges, player bit after 40 quiet cycles
E 2 0 1 1
E 2 0 0 0
E 4 1 0 1
E 30 1 0 1
E 10 1 0 0
E 4 0 1 0
E 40 0 1 1

//--- bench/cpc_glue_tb.sv
//////////////////////////////
// Run from the project root, steps come from bench/cpc_glue_testdata.txt
// EAR autostop is cut to 40 cycles
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cpc_glue_tb;

	localparam int max_steps = 256;
	localparam int line_bits = 8 * 160;

	logic         clk_sys;
	logic         reset;
	logic         status_reset;
	logic         model_664;
	logic         ioctl_download;
	logic         ioctl_wr;
	logic [7:0]   ioctl_index;
	logic [24:0]  ioctl_addr;
	logic [7:0]   ioctl_dout;
	logic [15:0]  ioctl_file_ext;
	logic [15:0]  cpu_addr;
	logic [7:0]   cpu_dout;
	logic         m1;
	logic         io_wr;
	logic         mem_rd;
	logic         mem_wr;
	logic         key_nmi;
	logic [1:0]   mf2_mode;
	logic         ear;
	logic         player_bit;

	wire          cpu_reset;
	wire          model;
	wire          boot_wr;
	wire  [22:0]  boot_addr;
	wire  [1:0]   boot_bank;
	wire  [7:0]   boot_dout;
	wire  [255:0] rom_map;
	wire          nmi;
	wire          mf2_rom_en;
	wire          mf2_ram_en;
	wire  [7:0]   mf2_dout;
	wire          tape_play;

	logic [line_bits-1:0] step_line [max_steps];
	int          step_count = 0;
	int          cycle_count = 0;
	int          cycle_limit = 40 * max_steps + 200;
	logic [31:0] rand_state = 32'd93526;

	cpc_glue_top #(
		.autostop_cycles (32'd40)
	) UUT (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.status_reset_i   (status_reset),
		.model_664_i      (model_664),
		.ioctl_download_i (ioctl_download),
		.ioctl_wr_i       (ioctl_wr),
		.ioctl_index_i    (ioctl_index),
		.ioctl_addr_i     (ioctl_addr),
		.ioctl_dout_i     (ioctl_dout),
		.ioctl_file_ext_i (ioctl_file_ext),
		.cpu_addr_i       (cpu_addr),
		.cpu_dout_i       (cpu_dout),
		.m1_i             (m1),
		.io_wr_i          (io_wr),
		.mem_rd_i         (mem_rd),
		.mem_wr_i         (mem_wr),
		.key_nmi_i        (key_nmi),
		.mf2_mode_i       (mf2_mode),
		.ear_i            (ear),
		.player_bit_i     (player_bit),
		.cpu_reset_o      (cpu_reset),
		.model_o          (model),
		.boot_wr_o        (boot_wr),
		.boot_addr_o      (boot_addr),
		.boot_bank_o      (boot_bank),
		.boot_dout_o      (boot_dout),
		.rom_map_o        (rom_map),
		.nmi_o            (nmi),
		.mf2_rom_en_o     (mf2_rom_en),
		.mf2_ram_en_o     (mf2_ram_en),
		.mf2_dout_o       (mf2_dout),
		.tape_play_o      (tape_play)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 8 ns period
	end

	task automatic stop_run();
		$display("Something failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] t=%0t ns %s expected %0h actual %0h", $time, name,
				expected, actual);
			stop_run();
		end
	endtask

	task automatic report_bad_line(input int step_no);
		$display("Test step %0d in the data file has missing or unreadable fields", step_no);
		stop_run();
	endtask

	// LCG, bytes for the download data path
	function automatic logic [7:0] next_random();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state[23:16];
	endfunction

	// Registered outputs are stable 2 ns after the edge
	task automatic settle(input int cycles);
		repeat (cycles) @(posedge clk_sys);
		#2;
	endtask

	//////////////////////////////
	// One task per step kind

	task automatic loader_step(input logic [line_bits-1:0] text, input int step_no);
		logic [7:0]  kind;
		logic [31:0] f [9];
		logic [7:0]  data;
		int          cycles;
		int          n;
		n = $sscanf(text, "%s %d %h %h %h %h %h %h %h %h %h", kind, cycles,
			f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
		if (n != 11) begin
			report_bad_line(step_no);
		end else begin
			data = next_random();
			@(negedge clk_sys);
			ioctl_download = f[0][0];
			ioctl_wr = f[1][0];
			ioctl_index = f[2][7:0];
			ioctl_addr = f[3][24:0];
			ioctl_file_ext = f[4][15:0]; // Two ASCII characters
			ioctl_dout = data;
			settle(cycles);
			check_value("cpu_reset_o", f[5], cpu_reset);
			check_value("boot_wr_o", f[6], boot_wr);
			check_value("boot_addr_o", f[7], boot_addr);
			check_value("boot_bank_o", f[8], boot_bank);
			check_value("boot_dout_o", data, boot_dout); // Data passes straight through
		end
	endtask

	task automatic map_step(input logic [line_bits-1:0] text, input int step_no);
		logic [7:0]  kind;
		logic [31:0] f [2];
		int          cycles;
		int          n;
		n = $sscanf(text, "%s %d %h %h", kind, cycles, f[0], f[1]);
		if (n != 4) begin
			report_bad_line(step_no);
		end else begin
			@(negedge clk_sys);
			settle(cycles);
			check_value($sformatf("rom_map_o[%0h]", f[0][7:0]), f[1], rom_map[f[0][7:0]]);
		end
	endtask

	task automatic cpu_step(input logic [line_bits-1:0] text, input int step_no);
		logic [7:0]  kind;
		logic [31:0] f [12];
		int          cycles;
		int          n;
		n = $sscanf(text, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h", kind, cycles,
			f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
		if (n != 14) begin
			report_bad_line(step_no);
		end else begin
			@(negedge clk_sys);
			key_nmi = f[0][0];
			mf2_mode = f[1][1:0];
			cpu_addr = f[2][15:0];
			cpu_dout = f[3][7:0];
			m1 = f[4][0];
			io_wr = f[5][0];
			mem_rd = f[6][0];
			mem_wr = f[7][0];
			settle(cycles);
			check_value("nmi_o", f[8], nmi);
			check_value("mf2_rom_en_o", f[9], mf2_rom_en);
			check_value("mf2_ram_en_o", f[10], mf2_ram_en);
			check_value("mf2_dout_o", f[11], mf2_dout);
		end
	endtask

	task automatic ear_step(input logic [line_bits-1:0] text, input int step_no);
		logic [7:0]  kind;
		logic [31:0] f [3];
		int          cycles;
		int          n;
		n = $sscanf(text, "%s %d %h %h %h", kind, cycles, f[0], f[1], f[2]);
		if (n != 5) begin
			report_bad_line(step_no);
		end else begin
			@(negedge clk_sys);
			ear = f[0][0];
			player_bit = f[1][0];
			settle(cycles);
			check_value("tape_play_o", f[2], tape_play);
		end
	endtask

	task automatic run_step(input logic [line_bits-1:0] text, input int step_no);
		logic [7:0] kind;
		int         n;
		n = $sscanf(text, "%s", kind);
		if (n != 1) begin
			report_bad_line(step_no);
		end else begin
			case (kind)
				"L": loader_step(text, step_no);
				"M": map_step(text, step_no);
				"C": cpu_step(text, step_no);
				"E": ear_step(text, step_no);
				default: report_bad_line(step_no);
			endcase
		end
	endtask

	// Model bit is taken only while the core is held in reset
	task automatic model_latch_check();
		@(negedge clk_sys);
		status_reset = 1'b1;
		model_664 = 1'b1;
		settle(2);
		check_value("cpu_reset_o", 1'b1, cpu_reset);
		check_value("model_o", 1'b1, model);
		@(negedge clk_sys);
		status_reset = 1'b0;
		settle(2);
		check_value("cpu_reset_o", 1'b0, cpu_reset);
		check_value("model_o", 1'b1, model);
		@(negedge clk_sys);
		model_664 = 1'b0; // Core running, must be ignored
		settle(2);
		check_value("model_o", 1'b1, model);
	endtask

	task automatic load_steps();
		logic [line_bits-1:0] text;
		logic [7:0]           kind;
		int                   fd;
		int                   n;
		fd = $fopen("bench/cpc_glue_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/cpc_glue_testdata.txt");
			stop_run();
		end else begin
			text = '0;
			while ($fgets(text, fd) != 0) begin
				n = $sscanf(text, "%s", kind);
				if (n == 1 && kind != "#") begin // Skips blank and comment lines
					if (step_count < max_steps)
						step_line[step_count] = text;
					step_count++;
				end
				text = '0;
			end
			$fclose(fd);
			if (step_count == 0 || step_count > max_steps) begin
				$display("Data file holds %0d steps, only 1 to %0d can be run",
					step_count, max_steps);
				stop_run();
			end
		end
	endtask

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout, the steps did not finish within %0d cycles", cycle_limit);
			stop_run();
		end
	end

	initial begin
		int step_idx;
		reset = 1'b1;
		status_reset = 1'b0;
		model_664 = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = 25'd0;
		ioctl_dout = 8'd0;
		ioctl_file_ext = 16'd0;
		cpu_addr = 16'd0;
		cpu_dout = 8'd0;
		m1 = 1'b0;
		io_wr = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		key_nmi = 1'b0;
		mf2_mode = 2'd0;
		ear = 1'b0;
		player_bit = 1'b0;
		load_steps();
		cycle_limit = 40 * step_count + 200;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
		for (step_idx = 0; step_idx < step_count; step_idx++)
			run_step(step_line[step_idx], step_idx + 1);
		model_latch_check();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/cpc_glue_top.sv
//////////////////////////////
// CPC glue around an external core, CPU bus is snooped
// mf2_dout_o is FFh when the MF2 RAM is not read
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cpc_glue_top #(
	parameter logic [31:0] autostop_cycles = cpc_glue_pkg::ear_autostop_cycles
) (
	input  wire          clk_sys,
	input  wire          reset,
	input  wire          status_reset_i,
	input  wire          model_664_i,
	input  wire          ioctl_download_i,
	input  wire          ioctl_wr_i,
	input  wire  [7:0]   ioctl_index_i,
	input  wire  [24:0]  ioctl_addr_i,
	input  wire  [7:0]   ioctl_dout_i,
	input  wire  [15:0]  ioctl_file_ext_i,
	input  wire  [15:0]  cpu_addr_i,
	input  wire  [7:0]   cpu_dout_i,
	input  wire          m1_i,
	input  wire          io_wr_i,
	input  wire          mem_rd_i,
	input  wire          mem_wr_i,
	input  wire          key_nmi_i,
	input  wire  [1:0]   mf2_mode_i,
	input  wire          ear_i,
	input  wire          player_bit_i,
	output wire          cpu_reset_o,
	output wire          model_o,
	output wire          boot_wr_o,
	output wire  [22:0]  boot_addr_o,
	output wire  [1:0]   boot_bank_o,
	output wire  [7:0]   boot_dout_o,
	output wire  [255:0] rom_map_o,
	output wire          nmi_o,
	output wire          mf2_rom_en_o,
	output wire          mf2_ram_en_o,
	output wire  [7:0]   mf2_dout_o,
	output wire          tape_play_o
);

	wire mf2_en;

	cpu_bus_if bus ();

	assign bus.cpu_addr = cpu_addr_i;
	assign bus.cpu_dout = cpu_dout_i;
	assign bus.m1 = m1_i;
	assign bus.io_wr = io_wr_i;
	assign bus.mem_rd = mem_rd_i;
	assign bus.mem_wr = mem_wr_i;

	//////////////////////////////
	// Loader and reset

	boot_loader_map u_boot (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ioctl_file_ext_i (ioctl_file_ext_i),
		.status_reset_i   (status_reset_i),
		.model_664_i      (model_664_i),
		.cpu_reset_o      (cpu_reset_o),
		.model_o          (model_o),
		.boot_wr_o        (boot_wr_o),
		.boot_addr_o      (boot_addr_o),
		.boot_bank_o      (boot_bank_o),
		.boot_dout_o      (boot_dout_o),
		.rom_map_o        (rom_map_o)
	);

	//////////////////////////////
	// Multiface Two

	mf2_controller u_mf2_ctrl (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.key_nmi_i  (key_nmi_i),
		.mf2_mode_i (cpc_glue_pkg::mf2_mode_e'(mf2_mode_i)),
		.nmi_o      (nmi_o),
		.mf2_en_o   (mf2_en),
		.rom_en_o   (mf2_rom_en_o),
		.ram_en_o   (mf2_ram_en_o)
	);

	mf2_shadow_ram u_mf2_ram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.mf2_en_i   (mf2_en),
		.mf2_dout_o (mf2_dout_o)
	);

	ear_input_select #(
		.autostop_cycles (autostop_cycles)
	) u_ear (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ear_i        (ear_i),
		.player_bit_i (player_bit_i),
		.tape_play_o  (tape_play_o)
	);

endmodule

`default_nettype wire

//--- source/ear_input_select.sv
//////////////////////////////
// EAR wins while it toggles, player bit after a quiet period
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ear_input_select #(
	parameter logic [31:0] autostop_cycles = cpc_glue_pkg::ear_autostop_cycles
) (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  ear_i,
	input  wire  player_bit_i,
	output logic tape_play_o
);

	logic        ear_s1;
	logic        ear_s2;
	logic        ear_s3;
	logic [31:0] quiet_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear_s1 <= 1'b0;
			ear_s2 <= 1'b0;
			ear_s3 <= 1'b0;
			quiet_cnt <= 32'd0;
			tape_play_o <= 1'b0;
		end else begin
			ear_s1 <= ear_i; // Asynchronous input
			ear_s2 <= ear_s1;
			ear_s3 <= ear_s2;
			if (ear_s3 ^ ear_s2)
				quiet_cnt <= autostop_cycles; // Edge seen, hold EAR
			else if (quiet_cnt != 32'd0)
				quiet_cnt <= quiet_cnt - 32'd1;
			tape_play_o <= (quiet_cnt != 32'd0) ? ear_s3 : player_bit_i;
		end
	end

endmodule

`default_nettype wire

//--- source/mf2_shadow_ram.sv
//////////////////////////////
// Shadows GA, CRTC, PPI and ROM select writes into MF2 RAM
// Stores happen whether or not the interface is paged in
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mf2_shadow_ram (
	input  wire        clk_sys,
	input  wire        reset,
	cpu_bus_if.snoop   bus,
	input  wire        mf2_en_i,
	output logic [7:0] mf2_dout_o
);

	logic        io_wr_q;
	logic        io_wr_rise;
	logic        ram_sel;
	logic        store_req;
	logic        mem_req;
	logic [12:0] store_addr;
	logic [4:0]  pen_index;
	logic [3:0]  crtc_reg;
	logic [12:0] ram_a;
	logic [7:0]  ram_in;
	logic [7:0]  ram_out;
	logic        ram_we;
	logic [7:0]  ram [8192];

	assign io_wr_rise = bus.io_wr & ~io_wr_q;
	assign ram_sel = mf2_en_i && (bus.cpu_addr[15:13] == 3'b001);
	assign store_req = io_wr_rise & (|store_addr);
	assign mem_req = bus.mem_wr & ram_sel;

	always_comb begin
		case (bus.cpu_addr[15:8])
			8'h7F: begin // Gate array, function in bits 7:6
				case (bus.cpu_dout[7:6])
					2'b00: store_addr = 13'h1FCF;
					2'b01: store_addr = pen_index[4] ? 13'h1FDF : {9'h1F9, pen_index[3:0]};
					2'b10: store_addr = 13'h1FEF; // Screen mode
					default: store_addr = 13'h1FFF; // RAM banking
				endcase
			end
			8'hBC: store_addr = 13'h1CFF; // CRTC index
			8'hBD: store_addr = {9'h1DB, crtc_reg};
			8'hF7: store_addr = 13'h17FF; // 8255 control
			8'hDF: store_addr = 13'h1AAC;
			default: store_addr = 13'h0000; // Not shadowed
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			ram_we <= 1'b0;
			pen_index <= 5'd0;
			crtc_reg <= 4'd0;
		end else begin
			io_wr_q <= bus.io_wr;
			ram_we <= store_req | mem_req;
			if (store_req && bus.cpu_addr[15:8] == 8'h7F && bus.cpu_dout[7:6] == 2'b00)
				pen_index <= bus.cpu_dout[4:0];
			if (store_req && bus.cpu_addr[15:8] == 8'hBC)
				crtc_reg <= bus.cpu_dout[3:0];
		end
	end

	// Port stores take the address, otherwise the CPU window
	always_ff @(posedge clk_sys) begin
		ram_a <= store_req ? store_addr : bus.cpu_addr[12:0];
		ram_in <= bus.cpu_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out <= ram_in; // Write-through
		end else
			ram_out <= ram[ram_a];
	end

	assign mf2_dout_o = (ram_sel && bus.mem_rd) ? ram_out : 8'hFF;

	a_store_vs_mem: assert property (@(posedge clk_sys) disable iff (reset)
		!(store_req && mem_req))
		else $error("MF2 register store and RAM write in one cycle");

endmodule

`default_nettype wire

//--- source/mf2_controller.sv
//////////////////////////////
// Multiface Two paging, NMI entry at 0066h
// Port writes are ignored while an NMI is pending
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mf2_controller (
	input  wire                      clk_sys,
	input  wire                      reset,
	cpu_bus_if.snoop                 bus,
	input  wire                      key_nmi_i,
	input  wire cpc_glue_pkg::mf2_mode_e mf2_mode_i,
	output logic                     nmi_o,
	output logic                     mf2_en_o,
	output logic                     rom_en_o,
	output logic                     ram_en_o
);

	cpc_glue_pkg::mf2_state_e state;
	logic hidden_q; // Blocks the FEE8h enable
	logic key_q;
	logic m1_q;
	logic io_wr_q;
	logic key_rise;
	logic m1_rise;
	logic port_wr;
	logic disabled;

	assign key_rise = key_nmi_i & ~key_q;
	assign m1_rise = bus.m1 & ~m1_q;
	assign port_wr = bus.io_wr & ~io_wr_q & (bus.cpu_addr[15:2] == cpc_glue_pkg::mf2_port_hi);
	assign disabled = (mf2_mode_i == cpc_glue_pkg::mf2_disabled);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_q <= 1'b0;
			m1_q <= 1'b0;
			io_wr_q <= 1'b0;
			state <= cpc_glue_pkg::mf2_idle;
			hidden_q <= (mf2_mode_i == cpc_glue_pkg::mf2_hidden);
		end else begin
			key_q <= key_nmi_i;
			m1_q <= bus.m1;
			io_wr_q <= bus.io_wr;
			case (state)
				cpc_glue_pkg::mf2_idle: begin
					if (key_rise && !disabled)
						state <= cpc_glue_pkg::mf2_nmi_pending;
					else if (port_wr && !bus.cpu_addr[1] && !hidden_q && !disabled)
						state <= cpc_glue_pkg::mf2_active; // FEE8h
				end
				cpc_glue_pkg::mf2_nmi_pending: begin
					if (m1_rise && bus.cpu_addr == cpc_glue_pkg::mf2_nmi_vector) begin
						state <= cpc_glue_pkg::mf2_active;
						hidden_q <= 1'b0;
					end
				end
				cpc_glue_pkg::mf2_active: begin
					if (m1_rise && bus.cpu_addr == cpc_glue_pkg::mf2_hide_vector) begin
						state <= cpc_glue_pkg::mf2_active_hidden;
						hidden_q <= 1'b1;
					end else if (port_wr && (bus.cpu_addr[1] || disabled))
						state <= cpc_glue_pkg::mf2_idle;
				end
				default: begin
					if (port_wr)
						state <= cpc_glue_pkg::mf2_idle; // Hidden, any port write pages out
				end
			endcase
		end
	end

	assign nmi_o = (state == cpc_glue_pkg::mf2_nmi_pending);
	assign mf2_en_o = (state == cpc_glue_pkg::mf2_active) ||
		(state == cpc_glue_pkg::mf2_active_hidden);
	assign rom_en_o = mf2_en_o && (bus.cpu_addr[15:13] == 3'b000); // 0000h-1FFFh
	assign ram_en_o = mf2_en_o && (bus.cpu_addr[15:13] == 3'b001); // 2000h-3FFFh

	// Paged in, the hide flag must match the hidden state
	a_hide_flag: assert property (@(posedge clk_sys) disable iff (reset)
		mf2_en_o |-> (hidden_q == (state == cpc_glue_pkg::mf2_active_hidden)))
		else $error("MF2 hide flag out of step with the paging state");

endmodule

`default_nettype wire

//--- source/boot_loader_map.sv
//////////////////////////////
// Lower 4 MB holds OS, RAM pages and MF2 ROM, upper 4 MB the high ROMs
// Only ROM and expansion downloads are mapped
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module boot_loader_map (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       ioctl_download_i,
	input  wire                       ioctl_wr_i,
	input  wire  [7:0]                ioctl_index_i,
	input  wire  [24:0]               ioctl_addr_i,
	input  wire  [7:0]                ioctl_dout_i,
	input  wire  [15:0]               ioctl_file_ext_i,
	input  wire                       status_reset_i,
	input  wire                       model_664_i,
	output logic                      cpu_reset_o,
	output logic                      model_o,
	output logic                      boot_wr_o,
	output logic [22:0]               boot_addr_o,
	output cpc_glue_pkg::boot_bank_e  boot_bank_o,
	output logic [7:0]                boot_dout_o,
	output logic [255:0]              rom_map_o
);

	logic       rom_dl;
	logic       ext_dl;
	logic       old_download;
	logic       old_wr;
	logic       wr_fall;
	logic       combo;
	logic       combo_clear;
	logic [8:0] ext_page;

	assign rom_dl = ioctl_download_i && (ioctl_index_i == cpc_glue_pkg::idx_rom);
	assign ext_dl = ioctl_download_i && (ioctl_index_i == cpc_glue_pkg::idx_ext);
	assign wr_fall = (rom_dl | ext_dl) & old_wr & ~ioctl_wr_i;
	assign combo_clear = wr_fall & combo & (&boot_addr_o[13:0]); // Last byte of the block

	ext_page_decoder u_ext_page (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.start_i       (ext_dl & ~old_download),
		.file_ext_i    (ioctl_file_ext_i),
		.combo_clear_i (combo_clear),
		.page_o        (ext_page),
		.combo_o       (combo)
	);

	always_comb begin
		boot_wr_o = (rom_dl | ext_dl) & ioctl_wr_i;
		boot_dout_o = ioctl_dout_i;
		boot_addr_o = {9'h1FF, ioctl_addr_i[13:0]};
		boot_bank_o = cpc_glue_pkg::bank_6128;
		if (ext_dl) begin
			boot_addr_o[22] = ext_page[8];
			boot_addr_o[21:14] = ext_page[7:0] + ioctl_addr_i[21:14];
			boot_bank_o = model_o ? cpc_glue_pkg::bank_664 : cpc_glue_pkg::bank_6128;
		end else begin
			case (ioctl_addr_i[24:14])
				11'd0, 11'd4: boot_addr_o[22:14] = cpc_glue_pkg::os_page;
				11'd1, 11'd5: boot_addr_o[22:14] = cpc_glue_pkg::basic_page;
				11'd2, 11'd6: boot_addr_o[22:14] = cpc_glue_pkg::amsdos_page;
				11'd3, 11'd7: boot_addr_o[22:14] = cpc_glue_pkg::mf2_page;
				default: boot_wr_o = 1'b0; // Past the last image
			endcase
			if (ioctl_addr_i[24:16] == 9'd1)
				boot_bank_o = cpc_glue_pkg::bank_664; // Chunks 4 to 7
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			old_wr <= 1'b0;
			cpu_reset_o <= 1'b1;
			model_o <= 1'b0;
			rom_map_o <= '0;
		end else begin
			old_download <= ioctl_download_i;
			old_wr <= ioctl_wr_i;
			cpu_reset_o <= status_reset_i | rom_dl | ext_dl;
			if (cpu_reset_o)
				model_o <= model_664_i; // Model only changes across a core reset
			if (wr_fall && boot_addr_o[22])
				rom_map_o[boot_addr_o[21:14]] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/ext_page_decoder.sv
//////////////////////////////
// Extension E?? gives the ROM page as two hex digits
// Only upper case A-F is accepted
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ext_page_decoder (
	input  wire         clk_sys,
	input  wire         reset,
	input  wire         start_i,
	input  wire  [15:0] file_ext_i,
	input  wire         combo_clear_i,
	output logic [8:0]  page_o,
	output logic        combo_o
);

	logic [4:0] hi_nib; // Valid flag and value
	logic [4:0] lo_nib;
	logic [8:0] next_page;
	logic       next_combo;

	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	always_comb begin
		hi_nib = hex_digit(file_ext_i[15:8]);
		lo_nib = hex_digit(file_ext_i[7:0]);
		next_page = cpc_glue_pkg::page_hole; // Bit 8 stays set for hex pages
		next_combo = 1'b0;
		if (hi_nib[4])
			next_page[7:4] = hi_nib[3:0];
		if (lo_nib[4])
			next_page[3:0] = lo_nib[3:0];
		if (file_ext_i == "ZZ")
			next_page = 9'd0; // System ROM area
		if (file_ext_i == "Z0") begin
			next_page = 9'd0;
			next_combo = 1'b1; // Runs on into the high pages
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_o <= cpc_glue_pkg::page_hole;
			combo_o <= 1'b0;
		end else if (start_i) begin
			page_o <= next_page;
			combo_o <= next_combo;
		end else if (combo_clear_i) begin
			page_o <= cpc_glue_pkg::page_combo_end;
			combo_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_bus_if.sv
//////////////////////////////
// Snooped Z80 bus, no handshake
// Users sample every clk_sys edge and find their own edges
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface cpu_bus_if;

	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout; // Data written by the CPU
	logic        m1;
	logic        io_wr;
	logic        mem_rd;
	logic        mem_wr;

	// Listeners only
	modport snoop (
		input cpu_addr,
		input cpu_dout,
		input m1,
		input io_wr,
		input mem_rd,
		input mem_wr
	);

endinterface

`default_nettype wire

//--- source/cpc_glue_pkg.sv
//////////////////////////////
// Constants and enums for the CPC glue blocks
// Page numbers are 16 KB units inside one 8 MB SDRAM bank
//////////////////////////////
`default_nettype none

package cpc_glue_pkg;

	// Host download index
	localparam logic [7:0] idx_rom = 8'd0;
	localparam logic [7:0] idx_ext = 8'd3;

	localparam logic [8:0] page_hole      = 9'h1EE; // Unused page for a bad extension
	localparam logic [8:0] page_combo_end = 9'h1FF;

	// Boot image pages
	localparam logic [8:0] os_page     = 9'h000;
	localparam logic [8:0] basic_page  = 9'h100;
	localparam logic [8:0] amsdos_page = 9'h107;
	localparam logic [8:0] mf2_page    = 9'h0FF;

	localparam logic [13:0] mf2_port_hi     = 14'b1111_1110_1110_10; // FEE8h and FEEAh
	localparam logic [15:0] mf2_nmi_vector  = 16'h0066;
	localparam logic [15:0] mf2_hide_vector = 16'h0065;

	localparam logic [31:0] ear_autostop_cycles = 32'd320_000_000; // 5 s at 64 MHz

	// Menu setting, same order as the OSD option
	typedef enum logic [1:0] {
		mf2_enabled  = 2'd0,
		mf2_hidden   = 2'd1,
		mf2_disabled = 2'd2
	} mf2_mode_e;

	typedef enum logic [1:0] {
		mf2_idle,
		mf2_nmi_pending,
		mf2_active,
		mf2_active_hidden
	} mf2_state_e;

	typedef enum logic [1:0] {
		bank_6128 = 2'd0,
		bank_664  = 2'd1
	} boot_bank_e;

endpackage

`default_nettype wire
